//--- common/zmem_pkg.sv
/* Widths, types, reset pages and DRAM timing shared by the paged memory RTL.
   Modules pull it in with a wildcard import in the body. */

`default_nettype none

package zmem_pkg;

	//////////////////////////////////////////////////////////////////////////
	// memory map

	// four 16K windows in the Z80 space
	localparam int NUM_WIN = 4;

	// 48K layout: ROM, screen page, page 2, page 0
	localparam logic [7:0] PAGE_RESET_0 = 8'd0;
	localparam logic [7:0] PAGE_RESET_1 = 8'd5;
	localparam logic [7:0] PAGE_RESET_2 = 8'd2;
	localparam logic [7:0] PAGE_RESET_3 = 8'd0;

	// word offset inside a 16K page
	localparam int WOFF_W = 13;

	//////////////////////////////////////////////////////////////////////////
	// video and DRAM

	localparam logic [7:0] SCREEN_PAGE = 8'd5;
	localparam int SCREEN_WORDS = 256;

	// the model keeps only this many words, upper address bits fold away
	localparam int MEM_WORDS = 4096;
	localparam int MEM_AW = $clog2(MEM_WORDS);

	// accept to done, in fclk cycles
	localparam int DRAM_SLOT = 4;
	localparam int SLOT_W = $clog2(DRAM_SLOT + 1);

	//////////////////////////////////////////////////////////////////////////
	// types

	typedef logic [15:0] zaddr_t;
	typedef logic [7:0] zdata_t;
	typedef logic [7:0] page_t;
	typedef logic [$clog2(NUM_WIN)-1:0] win_t;
	typedef logic [$bits(page_t)+WOFF_W-1:0] waddr_t;
	typedef logic [15:0] word_t;
	typedef logic [1:0] bsel_t;

	typedef enum logic [1:0]
	{
		CS_IDLE,
		CS_DRAM,
		CS_ACK
	} ctrl_state_t;

	typedef enum logic [1:0]
	{
		DS_IDLE,
		DS_BUSY,
		DS_DONE
	} dram_state_t;

endpackage

`default_nettype wire

//--- design/cpu_port.sv
/* Wishbone classic slave for the Z80 side. Bit 16 of the address selects
   the page registers, otherwise the access goes through a window into DRAM. */

`timescale 1ns/10ps
`default_nettype none

module cpu_port
(
	input  wire                   fclk,
	input  wire                   rst_n,

	// wishbone classic slave
	input  wire                   wb_cyc,
	input  wire                   wb_stb,
	input  wire                   wb_we,
	input  wire [16:0]            wb_adr,
	input  wire zmem_pkg::zdata_t wb_dat_w,
	output zmem_pkg::zdata_t      wb_dat_r,
	output logic                  wb_ack,

	// DRAM master side
	output logic                  cpu_req,
	output zmem_pkg::waddr_t      cpu_waddr,
	output logic                  cpu_rnw,
	output zmem_pkg::word_t       cpu_wdata,
	output zmem_pkg::bsel_t       cpu_bsel,
	input  wire                   cpu_done,
	input  wire zmem_pkg::word_t  cpu_rdata
);

	import zmem_pkg::*;

	ctrl_state_t state;
	page_t rd_page;
	page_t xlat_page;
	logic start;
	logic is_io;
	logic rom_wr;

	assign start = (state == CS_IDLE) && wb_cyc && wb_stb;
	assign is_io = wb_adr[16];
	// window 0 holds ROM, writes there are swallowed
	assign rom_wr = !is_io && wb_we && (wb_adr[15:14] == 2'd0);

	page_regs u_page_regs
	(
		.fclk     (fclk),
		.rst_n    (rst_n),
		.wr       (start && is_io && wb_we),
		.wr_win   (wb_adr[1:0]),
		.wr_page  (wb_dat_w),
		.rd_win   (wb_adr[1:0]),
		.rd_page  (rd_page),
		.xlat_win (wb_adr[15:14]),
		.xlat_page(xlat_page)
	);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			state <= CS_IDLE;
		else
		begin
			case (state)
				CS_IDLE:
					if (start)
						state <= (is_io || rom_wr) ? CS_ACK : CS_DRAM;
				CS_DRAM:
					if (cpu_done)
						state <= CS_ACK;
				default:
					state <= CS_IDLE;
			endcase
		end
	end

	// master holds the bus request until ack, so the fields follow it directly
	assign cpu_req   = (state == CS_DRAM);
	assign cpu_waddr = {xlat_page, wb_adr[13:1]};
	assign cpu_rnw   = !wb_we;
	assign cpu_wdata = {2{wb_dat_w}};
	assign cpu_bsel  = wb_adr[0] ? 2'b10 : 2'b01;
	assign wb_ack    = (state == CS_ACK);

	always_ff @(posedge fclk)
	begin
		if (start && is_io)
			wb_dat_r <= rd_page;
		else if ((state == CS_DRAM) && cpu_done)
			wb_dat_r <= wb_adr[0] ? cpu_rdata[15:8] : cpu_rdata[7:0];
	end

	a_ack_in_cycle: assert property (@(posedge fclk) disable iff (!rst_n)
		wb_ack |-> wb_stb)
		else $error("wb_ack raised without wb_stb");

endmodule

`default_nettype wire

//--- design/page_regs.sv
/* Window page registers of the Z80 memory map.
   Written and read back from the I/O space, and used to translate CPU addresses. */

`timescale 1ns/10ps
`default_nettype none

module page_regs
(
	input  wire                  fclk,
	input  wire                  rst_n,

	// register write from the I/O space
	input  wire                  wr,
	input  wire zmem_pkg::win_t  wr_win,
	input  wire zmem_pkg::page_t wr_page,

	// read-back path
	input  wire zmem_pkg::win_t  rd_win,
	output zmem_pkg::page_t      rd_page,

	// translation path, window taken from address bits 15:14
	input  wire zmem_pkg::win_t  xlat_win,
	output zmem_pkg::page_t      xlat_page
);

	import zmem_pkg::*;

	page_t pages [NUM_WIN];

	// reset to the 48K layout
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pages[0] <= PAGE_RESET_0;
			pages[1] <= PAGE_RESET_1;
			pages[2] <= PAGE_RESET_2;
			pages[3] <= PAGE_RESET_3;
		end
		else if (wr)
		begin
			pages[wr_win] <= wr_page;
		end
	end

	// two independent read ports
	always_comb
	begin
		rd_page = pages[rd_win];
	end

	always_comb
	begin
		xlat_page = pages[xlat_win];
	end

endmodule

`default_nettype wire

//--- design/video_fetch.sv
/* Screen fetcher. While enabled it reads the screen page word by word
   through the arbiter and hands each word out with its index. */

`timescale 1ns/10ps
`default_nettype none

module video_fetch
(
	input  wire                  fclk,
	input  wire                  rst_n,

	input  wire                  video_ena,

	// DRAM master side, reads only
	output logic                 vid_req,
	output zmem_pkg::waddr_t     vid_waddr,
	input  wire                  vid_done,
	input  wire zmem_pkg::word_t vid_rdata,

	// pixel word stream
	output zmem_pkg::word_t      pix_word,
	output logic [7:0]           pix_index,
	output logic                 pix_valid
);

	import zmem_pkg::*;

	logic [7:0] word_cnt;

	assign vid_waddr = {SCREEN_PAGE, {(WOFF_W - 8){1'b0}}, word_cnt};

	// request stays up across words, drops only at the end of an access
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vid_req   <= 1'b0;
			word_cnt  <= '0;
			pix_valid <= 1'b0;
		end
		else
		begin
			pix_valid <= vid_done;
			if (!vid_req)
				vid_req <= video_ena;
			else if (vid_done)
			begin
				vid_req <= video_ena;
				if (word_cnt == 8'(SCREEN_WORDS - 1))
					word_cnt <= '0;
				else
					word_cnt <= word_cnt + 8'd1;
			end
		end
	end

	// returned word and the index it was fetched from
	always_ff @(posedge fclk)
	begin
		if (vid_done)
		begin
			pix_word  <= vid_rdata;
			pix_index <= word_cnt;
		end
	end

endmodule

`default_nettype wire

//--- design/zmem_top.sv
/* Top of the paged memory subsystem. The CPU port and the video fetcher
   share one DRAM through the arbiter. */

`timescale 1ns/10ps
`default_nettype none

module zmem_top
(
	input  wire                   fclk,
	input  wire                   rst_n,

	input  wire                   wb_cyc,
	input  wire                   wb_stb,
	input  wire                   wb_we,
	input  wire [16:0]            wb_adr,
	input  wire zmem_pkg::zdata_t wb_dat_w,
	output zmem_pkg::zdata_t      wb_dat_r,
	output logic                  wb_ack,

	input  wire                   video_ena,
	output zmem_pkg::word_t       pix_word,
	output logic [7:0]            pix_index,
	output logic                  pix_valid
);

	import zmem_pkg::*;

	// CPU master
	wire cpu_req, cpu_rnw, cpu_done;
	waddr_t cpu_waddr;
	word_t cpu_wdata, cpu_rdata;
	bsel_t cpu_bsel;

	// video master
	wire vid_req, vid_done;
	waddr_t vid_waddr;
	word_t vid_rdata;

	// arbiter to controller
	wire dram_req, dram_rnw, dram_done;
	waddr_t dram_waddr;
	word_t dram_wdata, dram_rdata;
	bsel_t dram_bsel;

	cpu_port u_cpu_port
	(
		.fclk(fclk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.cpu_req(cpu_req), .cpu_waddr(cpu_waddr), .cpu_rnw(cpu_rnw),
		.cpu_wdata(cpu_wdata), .cpu_bsel(cpu_bsel),
		.cpu_done(cpu_done), .cpu_rdata(cpu_rdata)
	);

	video_fetch u_video_fetch
	(
		.fclk(fclk), .rst_n(rst_n), .video_ena(video_ena),
		.vid_req(vid_req), .vid_waddr(vid_waddr),
		.vid_done(vid_done), .vid_rdata(vid_rdata),
		.pix_word(pix_word), .pix_index(pix_index), .pix_valid(pix_valid)
	);

	dram_arbiter u_dram_arbiter
	(
		.fclk(fclk), .rst_n(rst_n),
		.cpu_req(cpu_req), .cpu_waddr(cpu_waddr), .cpu_rnw(cpu_rnw),
		.cpu_wdata(cpu_wdata), .cpu_bsel(cpu_bsel),
		.cpu_done(cpu_done), .cpu_rdata(cpu_rdata),
		.vid_req(vid_req), .vid_waddr(vid_waddr),
		.vid_done(vid_done), .vid_rdata(vid_rdata),
		.dram_req(dram_req), .dram_waddr(dram_waddr), .dram_rnw(dram_rnw),
		.dram_wdata(dram_wdata), .dram_bsel(dram_bsel),
		.dram_done(dram_done), .dram_rdata(dram_rdata)
	);

	dram_ctrl u_dram_ctrl
	(
		.fclk(fclk), .rst_n(rst_n),
		.dram_req(dram_req), .dram_waddr(dram_waddr), .dram_rnw(dram_rnw),
		.dram_wdata(dram_wdata), .dram_bsel(dram_bsel),
		.dram_done(dram_done), .dram_rdata(dram_rdata)
	);

endmodule

`default_nettype wire

//--- dram/dram_arbiter.sv
/* Arbiter between the CPU port and the video fetcher for the single DRAM.
   Alternates on conflict and keeps the grant until the access is done. */

`timescale 1ns/10ps
`default_nettype none

module dram_arbiter
(
	input  wire                   fclk,
	input  wire                   rst_n,

	// CPU master
	input  wire                   cpu_req,
	input  wire zmem_pkg::waddr_t cpu_waddr,
	input  wire                   cpu_rnw,
	input  wire zmem_pkg::word_t  cpu_wdata,
	input  wire zmem_pkg::bsel_t  cpu_bsel,
	output logic                  cpu_done,
	output zmem_pkg::word_t       cpu_rdata,

	// video master, reads whole words
	input  wire                   vid_req,
	input  wire zmem_pkg::waddr_t vid_waddr,
	output logic                  vid_done,
	output zmem_pkg::word_t       vid_rdata,

	// to the controller
	output logic                  dram_req,
	output zmem_pkg::waddr_t      dram_waddr,
	output logic                  dram_rnw,
	output zmem_pkg::word_t       dram_wdata,
	output zmem_pkg::bsel_t       dram_bsel,
	input  wire                   dram_done,
	input  wire zmem_pkg::word_t  dram_rdata
);

	import zmem_pkg::*;

	logic busy;
	logic last_vid;
	logic pick_vid;
	logic grant_cpu;
	logic grant_vid;

	// on conflict the master that lost last time wins
	assign pick_vid = vid_req && (!cpu_req || !last_vid);

	// while busy the last winner is the current owner
	assign grant_vid = busy ? last_vid : pick_vid;
	assign grant_cpu = busy ? !last_vid : (cpu_req && !pick_vid);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy     <= 1'b0;
			last_vid <= 1'b0;
		end
		else if (!busy)
		begin
			if (cpu_req || vid_req)
			begin
				busy     <= 1'b1;
				last_vid <= pick_vid;
			end
		end
		else if (dram_done)
			busy <= 1'b0;
	end

	assign dram_req   = (grant_cpu && cpu_req) || (grant_vid && vid_req);
	assign dram_waddr = grant_vid ? vid_waddr : cpu_waddr;
	assign dram_rnw   = grant_vid ? 1'b1 : cpu_rnw;
	assign dram_wdata = cpu_wdata;
	assign dram_bsel  = grant_vid ? 2'b11 : cpu_bsel;

	assign cpu_done  = dram_done && grant_cpu;
	assign vid_done  = dram_done && grant_vid;
	assign cpu_rdata = dram_rdata;
	assign vid_rdata = dram_rdata;

	a_one_grant: assert property (@(posedge fclk) disable iff (!rst_n)
		!(grant_cpu && grant_vid))
		else $error("both DRAM masters granted");

endmodule

`default_nettype wire

//--- dram/dram_ctrl.sv
/* DRAM controller with a fixed access slot over a small word array.
   Takes a request only when idle and answers DRAM_SLOT cycles later. */

`timescale 1ns/10ps
`default_nettype none

module dram_ctrl
(
	input  wire                   fclk,
	input  wire                   rst_n,

	input  wire                   dram_req,
	input  wire zmem_pkg::waddr_t dram_waddr,
	input  wire                   dram_rnw,
	input  wire zmem_pkg::word_t  dram_wdata,
	input  wire zmem_pkg::bsel_t  dram_bsel,
	output logic                  dram_done,
	output zmem_pkg::word_t       dram_rdata
);

	import zmem_pkg::*;

	dram_state_t state;
	logic [SLOT_W-1:0] slot_cnt;
	logic accept;
	logic fire;

	// latched request
	waddr_t addr_q;
	logic rnw_q;
	word_t wdata_q;
	bsel_t bsel_q;

	word_t mem [MEM_WORDS];

	assign accept = (state == DS_IDLE) && dram_req;
	assign fire   = (state == DS_BUSY) && (slot_cnt == SLOT_W'(1));

	//////////////////////////////////////////////////////////////////////////
	// slot sequencer

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= DS_IDLE;
			slot_cnt  <= '0;
			dram_done <= 1'b0;
		end
		else
		begin
			dram_done <= fire;
			case (state)
				DS_IDLE:
					if (accept)
					begin
						state    <= DS_BUSY;
						slot_cnt <= SLOT_W'(DRAM_SLOT - 1);
					end
				DS_BUSY:
					if (fire)
						state <= DS_DONE;
					else
						slot_cnt <= slot_cnt - SLOT_W'(1);
				default:
					state <= DS_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// storage, folded onto MEM_WORDS

	always_ff @(posedge fclk)
	begin
		if (accept)
		begin
			addr_q  <= dram_waddr;
			rnw_q   <= dram_rnw;
			wdata_q <= dram_wdata;
			bsel_q  <= dram_bsel;
		end
		if (fire)
		begin
			dram_rdata <= mem[addr_q[MEM_AW-1:0]];
			if (!rnw_q && bsel_q[0])
				mem[addr_q[MEM_AW-1:0]][7:0] <= wdata_q[7:0];
			if (!rnw_q && bsel_q[1])
				mem[addr_q[MEM_AW-1:0]][15:8] <= wdata_q[15:8];
		end
	end

	a_done_busy: assert property (@(posedge fclk) disable iff (!rst_n)
		dram_done |-> state != DS_IDLE)
		else $error("dram_done while idle");

	a_slot: assert property (@(posedge fclk) disable iff (!rst_n)
		accept |-> ##DRAM_SLOT dram_done)
		else $error("dram_done not at end of slot");

endmodule

`default_nettype wire

//--- sim.f
common/zmem_pkg.sv
design/page_regs.sv
design/cpu_port.sv
design/video_fetch.sv
dram/dram_arbiter.sv
dram/dram_ctrl.sv
design/zmem_top.sv
testbench/tb_zmem.sv

//--- testbench/tb_zmem.sv
/* Testbench for the paged memory subsystem. Drives Wishbone transfers and the video
   enable into zmem_top, and checks page registers, memory bytes and the pixel stream
   against its own model. */

`timescale 1ns/10ps
`default_nettype none

module tb_zmem;

	import zmem_pkg::*;

	localparam int ACK_TIMEOUT = 40;
	localparam int PIX_TIMEOUT = 20000;

	logic fclk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [16:0] wb_adr;
	zdata_t wb_dat_w;
	zdata_t wb_dat_r;
	logic wb_ack;
	logic video_ena;
	word_t pix_word;
	logic [7:0] pix_index;
	logic pix_valid;

	// reference model
	page_t ref_page [4];
	zdata_t ref_mem [2*MEM_WORDS];
	logic [7:0] exp_index;
	int pix_count;
	int seed;
	logic [15:0] wr_q [$];

	zmem_top DUT
	(
		.fclk(fclk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.video_ena(video_ena), .pix_word(pix_word),
		.pix_index(pix_index), .pix_valid(pix_valid)
	);

	always #50 fclk = ~fclk;

	////////////////////////////////////////////////////////////////////////////
	// model and checking

	// byte position of a CPU address with the word address folded onto the DRAM size
	function automatic int byte_index(input logic [15:0] a);
		logic [20:0] w;
		w = {ref_page[a[15:14]], a[13:1]};
		return (w % MEM_WORDS) * 2 + a[0];
	endfunction

	function automatic zdata_t ref_read(input logic [15:0] a);
		return ref_mem[byte_index(a)];
	endfunction

	// screen word as the video should see it from page 5
	function automatic word_t ref_word(input logic [7:0] idx);
		logic [20:0] w;
		int i;
		w = {8'd5, 13'(idx)};
		i = w % MEM_WORDS;
		return {ref_mem[2*i+1], ref_mem[2*i]};
	endfunction

	function automatic logic [1:0] rand_win();
		int r;
		r = $random(seed);
		return 2'd1 + 2'($unsigned(r) % 3);
	endfunction

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1, "simulation stopped at %0t", $time);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("ERROR %s got %h expected %h at %0t", name, got, exp, $time));
	endtask

	// pixel stream compare
	always @(negedge fclk)
	begin
		if (rst_n && pix_valid)
		begin
			check("pix_index", pix_index, exp_index);
			check("pix_word", pix_word, ref_word(exp_index));
			exp_index = exp_index + 8'd1;
			pix_count = pix_count + 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// bus tasks

	// one classic transfer held until ack is seen
	task automatic wb_access(input logic io, input logic we, input logic [15:0] a,
		input zdata_t d, output zdata_t q);
		int n;
		@(posedge fclk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= {io, a};
		wb_dat_w <= d;
		n = 0;
		@(negedge fclk);
		while (!wb_ack)
		begin
			if (n == ACK_TIMEOUT)
				stop_run("Wishbone transfer got no ack within the timeout");
			n++;
			@(negedge fclk);
		end
		q = wb_dat_r;
		@(posedge fclk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic io_write(input logic [1:0] w, input page_t p);
		zdata_t q;
		wb_access(1'b1, 1'b1, {14'd0, w}, p, q);
		ref_page[w] = p;
	endtask

	task automatic io_read(input logic [1:0] w);
		zdata_t q;
		wb_access(1'b1, 1'b0, {14'd0, w}, 8'h00, q);
		check("wb_dat_r", q, ref_page[w]);
	endtask

	// window 0 is ROM so the model keeps its old byte there
	task automatic mem_write(input logic [15:0] a, input zdata_t d);
		zdata_t q;
		wb_access(1'b0, 1'b1, a, d, q);
		if (a[15:14] != 2'd0)
			ref_mem[byte_index(a)] = d;
	endtask

	task automatic mem_read(input logic [15:0] a);
		zdata_t q;
		wb_access(1'b0, 1'b0, a, 8'h00, q);
		check("wb_dat_r", q, ref_read(a));
	endtask

	task automatic wait_pix(input int target);
		int n;
		n = 0;
		while (pix_count < target)
		begin
			if (n == PIX_TIMEOUT)
				stop_run("video stream stalled, no pix_valid within the timeout");
			n++;
			@(negedge fclk);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// scenarios

	initial
	begin
		logic [15:0] a;
		int start;
		fclk = 1'b0;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		video_ena = 1'b0;
		seed = 32'hbbfd;
		exp_index = 8'd0;
		pix_count = 0;
		// 48K layout after reset
		ref_page[0] = 8'd0;
		ref_page[1] = 8'd5;
		ref_page[2] = 8'd2;
		ref_page[3] = 8'd0;

		repeat (4) @(posedge fclk);
		rst_n <= 1'b1;

		for (int w = 0; w < 4; w++)
			io_read(2'(w));

		// page write and read-back
		repeat (4)
		begin
			for (int w = 1; w < 4; w++)
			begin
				io_write(2'(w), 8'($random(seed)));
				io_read(2'(w));
			end
		end

		// random bytes through windows 1 to 3
		for (int i = 0; i < 32; i++)
		begin
			a = 16'($random(seed));
			a[15:14] = rand_win();
			mem_write(a, 8'($random(seed)));
			wr_q.push_back(a);
		end
		foreach (wr_q[i])
		begin
			mem_read(wr_q[i]);
			// bit 13 folds away in the DRAM
			mem_read(wr_q[i] ^ 16'h2000);
		end
		io_write(2'd2, ref_page[1]);
		foreach (wr_q[i])
		begin
			if (wr_q[i][15:14] == 2'd1)
				mem_read({2'd2, wr_q[i][13:0]});
		end

		// ROM window swallows the write
		io_write(2'd3, 8'd0);
		mem_write(16'hc123, 8'h5a);
		mem_write(16'h0123, 8'ha5);
		mem_read(16'hc123);
		mem_read(16'h0123);

		// fill the screen page and then start video
		io_write(2'd1, 8'd5);
		for (int i = 0; i < 2*SCREEN_WORDS; i++)
			mem_write(16'h4000 + 16'(i), 8'($random(seed)));
		@(posedge fclk);
		video_ena <= 1'b1;
		wait_pix(SCREEN_WORDS + 16);

		// CPU traffic against the running video away from the screen words
		io_write(2'd1, 8'd7);
		io_write(2'd2, 8'h33);
		io_write(2'd3, 8'hc0);
		wr_q.delete();
		start = pix_count;
		for (int i = 0; i < 48; i++)
		begin
			a = 16'($random(seed));
			a[15:14] = rand_win();
			a[12] = 1'b1;
			mem_write(a, 8'($random(seed)));
			wr_q.push_back(a);
			mem_read(wr_q[$unsigned($random(seed)) % wr_q.size()]);
		end
		wait_pix(start + 32);
		@(posedge fclk);
		video_ena <= 1'b0;

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire
